// ==== compile.f ====
he_pkg.sv
dp_ram.sv
wb_slave.sv
op_controller.sv
lwe_alu.sv
he_accel_top.sv
tb_he_accel.sv

// ==== Bender.yml ====
package:
  name: he_accel

sources:
  - he_pkg.sv
  - dp_ram.sv
  - wb_slave.sv
  - op_controller.sv
  - lwe_alu.sv
  - he_accel_top.sv
  - target: simulation
    files:
      - tb_he_accel.sv

// ==== tb_he_accel.sv ====
`timescale 1ns/10ps

module tb_he_accel;

	localparam logic [31:0] WB_BASE   = 32'h3000_0000;
	localparam int          DIMENSION = 2;
	localparam int          PT_WIDTH  = 6;
	localparam int          VEC       = DIMENSION + 1;
	localparam int          CLK_NS    = 4;
	localparam int          MAX_POLLS = 16;

	// reset read, add and decrypt runs, three ignored configs
	localparam int N_TRANS     = 1 + 2 * (2 * VEC + 2 + MAX_POLLS + VEC) + 3 * (2 + VEC);
	localparam int WATCHDOG_NS = 60 * N_TRANS * CLK_NS;

	localparam int OP1_BASE = 8'h10;
	localparam int OP2_BASE = 8'h20;
	localparam int KEY_BASE = 8'h30;
	localparam int CT_BASE  = 8'h50;
	localparam int OUT_BASE = 8'h40;

	logic            clk;
	logic            rst_n;
	he_pkg::wb_req_t wb_req;
	he_pkg::wb_rsp_t wb_rsp;

	he_pkg::word_t op_mem  [0:255]; // host view of the operand RAMs
	he_pkg::word_t res_exp [0:255];
	integer        seed;

	he_accel_top i_he_accel_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog timeout: a bus transfer or a run never completed");
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
	endtask

	// ack is a single-cycle pulse
	assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
		else value_error("ack high two cycles running");

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(wb_req.stb) && wb_req.we |=> wb_rsp.ack)
		else value_error("write ack not one cycle after the request");

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(wb_req.stb) && !wb_req.we |=> !wb_rsp.ack ##1 wb_rsp.ack)
		else value_error("read ack not two cycles after the request");

	task automatic wait_ack();
		do begin
			@(posedge clk);
			#1;
		end while (!wb_rsp.ack);
	endtask

	// every bus task starts and ends 1 ns after a rising edge
	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: 4'hf, adr: adr, dat: dat};
		wait_ack();
		wb_req = '0;
		@(posedge clk);
		#1;
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: 4'hf, adr: adr, dat: '0};
		wait_ack();
		dat    = wb_rsp.dat;
		wb_req = '0;
		@(posedge clk);
		#1;
	endtask

	task automatic read_status(output logic [31:0] st);
		bus_read(WB_BASE, st);
	endtask

	task automatic write_operand(input int idx, input he_pkg::word_t data);
		bus_write(WB_BASE + 32'd4 + 32'(4 * idx), data);
		op_mem[idx] = data;
	endtask

	task automatic fill_vector(input int base);
		he_pkg::word_t w;
		for (int k = 0; k < VEC; k++) begin
			w = $random(seed);
			write_operand(base + k, w);
		end
	endtask

	function automatic he_pkg::op_cfg_t make_cfg(input logic valid, input logic [1:0] op,
		input int op1, input int op2, input int out);
		he_pkg::op_cfg_t cfg;
		cfg          = '0;
		cfg.valid    = valid;
		cfg.opcode   = he_pkg::opcode_e'(op);
		cfg.op1_base = he_pkg::maddr_t'(op1);
		cfg.op2_base = he_pkg::maddr_t'(op2);
		cfg.out_base = he_pkg::maddr_t'(out);
		return cfg;
	endfunction

	// sum of products over the vectors, reduced to the plaintext width
	function automatic he_pkg::word_t decrypt_ref(input int key, input int ct);
		logic [63:0] acc;
		acc = '0;
		for (int k = 0; k < VEC; k++)
			acc += 64'(op_mem[key + k]) * 64'(op_mem[ct + k]);
		return he_pkg::word_t'(acc % (64'd1 << PT_WIDTH));
	endfunction

	task automatic check_results();
		logic [31:0] got;
		for (int k = 0; k < VEC; k++) begin
			bus_read(WB_BASE + 32'd4 + 32'(4 * (OUT_BASE + k)), got);
			assert (got == res_exp[OUT_BASE + k])
				else value_error($sformatf("result word %0d is %h, expected %h",
					OUT_BASE + k, got, res_exp[OUT_BASE + k]));
		end
	endtask

	task automatic run_op(input logic [1:0] op, input int op1, input int op2, input int out);
		logic [31:0] st;
		int          polls;
		bus_write(WB_BASE, make_cfg(1'b1, op, op1, op2, out));
		read_status(st);
		assert (st == 32'd0) else value_error($sformatf("status %h right after a config", st));
		polls = 0;
		while (st != 32'd1) begin
			if (polls == MAX_POLLS)
				abort_run("run did not set done within the allowed status reads");
			else begin
				read_status(st);
				assert (st inside {32'd0, 32'd1})
					else value_error($sformatf("status word %h has bits above done", st));
				polls++;
			end
		end
	endtask

	task automatic ignored_cfg(input logic valid, input logic [1:0] op);
		logic [31:0] st;
		bus_write(WB_BASE, make_cfg(valid, op, KEY_BASE, CT_BASE, OUT_BASE));
		read_status(st);
		assert (st == 32'd1)
			else value_error($sformatf("status %h after an ignored config", st));
		check_results();
	endtask

	initial begin
		logic [31:0] st;
		seed   = 42;
		wb_req = '0;
		rst_n  = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		assert (wb_rsp.ack == 1'b0 && wb_rsp.dat == '0)
			else value_error("bus response not idle after reset");
		read_status(st);
		assert (st == 32'd0) else value_error($sformatf("status %h after reset", st));

		// element-wise add
		fill_vector(OP1_BASE);
		fill_vector(OP2_BASE);
		run_op(2'b10, OP1_BASE, OP2_BASE, OUT_BASE);
		for (int k = 0; k < VEC; k++)
			res_exp[OUT_BASE + k] = op_mem[OP1_BASE + k] + op_mem[OP2_BASE + k];
		check_results();

		// decrypt into the middle word, neighbours keep the add results
		fill_vector(KEY_BASE);
		fill_vector(CT_BASE);
		run_op(2'b01, KEY_BASE, CT_BASE, OUT_BASE + 1);
		res_exp[OUT_BASE + 1] = decrypt_ref(KEY_BASE, CT_BASE);
		check_results();

		ignored_cfg(1'b0, 2'b10);
		ignored_cfg(1'b1, 2'b11);
		ignored_cfg(1'b1, 2'b00);

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== he_accel_top.sv ====
`timescale 1ns/10ps

module he_accel_top #(
	parameter logic [31:0] WB_BASE   = 32'h3000_0000,
	parameter int          DIMENSION = 2,
	parameter int          PT_WIDTH  = 6
) (
	input  logic            clk,
	input  logic            rst_n,
	input  he_pkg::wb_req_t wb_req_i,
	output he_pkg::wb_rsp_t wb_rsp_o
);
	he_pkg::mem_wr_t   host_wr;
	logic              cfg_wr;
	he_pkg::op_cfg_t   cfg;
	logic              res_rd_en;
	he_pkg::maddr_t    res_rd_addr;
	he_pkg::word_t     res_rdata;
	logic              done;
	logic              op_rd_en;
	he_pkg::maddr_t    op1_addr;
	he_pkg::maddr_t    op2_addr;
	he_pkg::word_t     op1_rdata;
	he_pkg::word_t     op2_rdata;
	he_pkg::alu_step_t step;
	he_pkg::res_wr_t   res_wr;

	wb_slave #(
		.WB_BASE(WB_BASE)
	) i_wb_slave (
		.clk           (clk),
		.rst_n         (rst_n),
		.wb_req_i      (wb_req_i),
		.wb_rsp_o      (wb_rsp_o),
		.host_wr_o     (host_wr),
		.cfg_wr_o      (cfg_wr),
		.cfg_o         (cfg),
		.res_rd_en_o   (res_rd_en),
		.res_rd_addr_o (res_rd_addr),
		.res_rdata_i   (res_rdata),
		.done_i        (done)
	);

	op_controller #(
		.DIMENSION(DIMENSION)
	) i_op_controller (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg_wr_i   (cfg_wr),
		.cfg_i      (cfg),
		.rd_en_o    (op_rd_en),
		.op1_addr_o (op1_addr),
		.op2_addr_o (op2_addr),
		.step_o     (step),
		.res_wr_i   (res_wr),
		.done_o     (done)
	);

	// both operand copies take every host write
	dp_ram op1_ram (
		.clk       (clk),
		.wr_i      (host_wr),
		.rd_en_i   (op_rd_en),
		.rd_addr_i (op1_addr),
		.rdata_o   (op1_rdata)
	);

	dp_ram op2_ram (
		.clk       (clk),
		.wr_i      (host_wr),
		.rd_en_i   (op_rd_en),
		.rd_addr_i (op2_addr),
		.rdata_o   (op2_rdata)
	);

	dp_ram res_ram (
		.clk       (clk),
		.wr_i      (res_wr.wr),
		.rd_en_i   (res_rd_en),
		.rd_addr_i (res_rd_addr),
		.rdata_o   (res_rdata)
	);

	lwe_alu #(
		.PT_WIDTH(PT_WIDTH)
	) i_lwe_alu (
		.clk      (clk),
		.rst_n    (rst_n),
		.step_i   (step),
		.op1_i    (op1_rdata),
		.op2_i    (op2_rdata),
		.res_wr_o (res_wr)
	);

endmodule

// ==== lwe_alu.sv ====
`timescale 1ns/10ps

module lwe_alu #(
	parameter int PT_WIDTH = 6
) (
	input  logic              clk,
	input  logic              rst_n,
	input  he_pkg::alu_step_t step_i,
	input  he_pkg::word_t     op1_i,
	input  he_pkg::word_t     op2_i,
	output he_pkg::res_wr_t   res_wr_o
);
	he_pkg::alu_step_t step_q;
	he_pkg::word_t     sum;
	he_pkg::word_t     prod;
	he_pkg::word_t     acc_next;
	he_pkg::word_t     acc_q;
	he_pkg::word_t     pt_word;
	logic              is_add;

	assign is_add = step_q.opcode == he_pkg::OP_ADD;
	assign sum    = op1_i + op2_i;
	assign prod   = op1_i * op2_i; // low word is enough for the pt reduction
	assign acc_next = step_q.first ? prod : acc_q + prod;
	assign pt_word  = {{(he_pkg::WORD_W - PT_WIDTH){1'b0}}, acc_next[PT_WIDTH-1:0]};

	// lines the step up with registered ram data
	always_ff @(posedge clk) begin
		step_q <= step_i;
		if (!rst_n)
			step_q.valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (step_q.valid && !is_add)
			acc_q <= acc_next;
	end

	always_ff @(posedge clk) begin
		res_wr_o.wr.addr <= step_q.out_addr;
		res_wr_o.wr.data <= is_add ? sum : pt_word;
		res_wr_o.wr.en   <= step_q.valid & (is_add | step_q.last);
		res_wr_o.last    <= step_q.valid & step_q.last;
		if (!rst_n) begin
			res_wr_o.wr.en <= 1'b0;
			res_wr_o.last  <= 1'b0;
		end
	end

endmodule

// ==== op_controller.sv ====
`timescale 1ns/10ps

module op_controller #(
	parameter int DIMENSION = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cfg_wr_i,
	input  he_pkg::op_cfg_t   cfg_i,
	output logic              rd_en_o,
	output he_pkg::maddr_t    op1_addr_o,
	output he_pkg::maddr_t    op2_addr_o,
	output he_pkg::alu_step_t step_o,
	input  he_pkg::res_wr_t   res_wr_i,
	output logic              done_o
);
	localparam int CNT_W = $clog2(DIMENSION + 2);

	logic            accept;
	logic            last_elem;
	logic            run_q;
	logic            done_q;
	logic [CNT_W-1:0] cnt_q;
	he_pkg::opcode_e opcode_q;
	he_pkg::maddr_t  op1_q;
	he_pkg::maddr_t  op2_q;
	he_pkg::maddr_t  out_q;

	// reserved opcodes and words without valid are dropped here
	assign accept = cfg_wr_i & cfg_i.valid &
		(cfg_i.opcode == he_pkg::OP_DECRYPT || cfg_i.opcode == he_pkg::OP_ADD);
	assign last_elem = cnt_q == CNT_W'(DIMENSION);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else if (accept) begin
			run_q  <= 1'b1; // restarts even mid-run
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			if (run_q) begin
				run_q <= ~last_elem;
				cnt_q <= last_elem ? '0 : cnt_q + 1'b1;
			end
			if (res_wr_i.wr.en && res_wr_i.last)
				done_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			opcode_q <= cfg_i.opcode;
			op1_q    <= cfg_i.op1_base;
			op2_q    <= cfg_i.op2_base;
			out_q    <= cfg_i.out_base;
		end else if (run_q) begin
			op1_q <= op1_q + 1'b1;
			op2_q <= op2_q + 1'b1;
			if (opcode_q == he_pkg::OP_ADD)
				out_q <= out_q + 1'b1; // decrypt keeps one output word
		end
	end

	assign rd_en_o    = run_q;
	assign op1_addr_o = op1_q;
	assign op2_addr_o = op2_q;

	assign step_o = '{
		valid:    run_q,
		opcode:   opcode_q,
		first:    cnt_q == '0,
		last:     last_elem,
		out_addr: out_q
	};

	assign done_o = done_q;

endmodule

// ==== wb_slave.sv ====
`timescale 1ns/10ps

module wb_slave #(
	parameter logic [31:0] WB_BASE = 32'h3000_0000
) (
	input  logic            clk,
	input  logic            rst_n,
	input  he_pkg::wb_req_t wb_req_i,
	output he_pkg::wb_rsp_t wb_rsp_o,
	output he_pkg::mem_wr_t host_wr_o,
	output logic            cfg_wr_o,
	output he_pkg::op_cfg_t cfg_o,
	output logic            res_rd_en_o,
	output he_pkg::maddr_t  res_rd_addr_o,
	input  he_pkg::word_t   res_rdata_i,
	input  logic            done_i
);
	logic           req;
	logic           access;
	logic           is_cfg;
	logic           is_data;
	logic [31:0]    offset;
	he_pkg::maddr_t index;
	logic           ack_q;
	logic           rd_pend_q;
	logic           rd_cfg_q;
	logic           rd_data_q;
	he_pkg::word_t  dat_q;

	assign req    = wb_req_i.cyc & wb_req_i.stb;
	assign access = req & ~ack_q & ~rd_pend_q; // one shot per request
	assign offset = wb_req_i.adr - (WB_BASE + 32'd4);
	assign is_cfg = wb_req_i.adr == WB_BASE;
	assign is_data = offset[31:he_pkg::ADDR_W+2] == '0; // wraps high below the window
	assign index  = offset[he_pkg::ADDR_W+1:2];

	assign host_wr_o = '{
		en:   access & wb_req_i.we & is_data,
		addr: index,
		data: wb_req_i.dat
	};
	assign cfg_wr_o = access & wb_req_i.we & is_cfg;
	assign cfg_o    = he_pkg::op_cfg_t'(wb_req_i.dat);

	assign res_rd_en_o   = access & ~wb_req_i.we & is_data;
	assign res_rd_addr_o = index;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q     <= 1'b0;
			rd_pend_q <= 1'b0;
		end else begin
			ack_q     <= (access & wb_req_i.we) | rd_pend_q;
			rd_pend_q <= access & ~wb_req_i.we; // wait one cycle for ram data
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rd_cfg_q  <= is_cfg;
			rd_data_q <= is_data;
		end
	end

	// status word keeps done in bit 0
	always_ff @(posedge clk) begin
		if (!rst_n)
			dat_q <= '0;
		else if (rd_pend_q) begin
			if (rd_data_q)
				dat_q <= res_rdata_i;
			else if (rd_cfg_q)
				dat_q <= he_pkg::word_t'(done_i);
			else
				dat_q <= '0; // unmapped
		end
	end

	assign wb_rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

// ==== dp_ram.sv ====
`timescale 1ns/10ps

module dp_ram (
	input  logic            clk,
	input  he_pkg::mem_wr_t wr_i,
	input  logic            rd_en_i,
	input  he_pkg::maddr_t  rd_addr_i,
	output he_pkg::word_t   rdata_o
);
	localparam int DEPTH = 1 << he_pkg::ADDR_W;

	he_pkg::word_t mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr_i.en)
			mem[wr_i.addr] <= wr_i.data;
	end

	// same-address read during a write sees the old word
	always_ff @(posedge clk) begin
		if (rd_en_i)
			rdata_o <= mem[rd_addr_i];
	end

endmodule

// ==== he_pkg.sv ====
package he_pkg;

	localparam int WORD_W = 32;
	localparam int ADDR_W = 8; // three bases share one config word

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] maddr_t;

	// 00 and 11 are reserved and start nothing
	typedef enum logic [1:0] {
		OP_DECRYPT = 2'b01,
		OP_ADD     = 2'b10
	} opcode_e;

	typedef struct packed {
		logic       valid;
		logic [4:0] spare;
		maddr_t     out_base;
		maddr_t     op2_base;
		maddr_t     op1_base;
		opcode_e    opcode;
	} op_cfg_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		word_t       dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	typedef struct packed {
		logic   en;
		maddr_t addr;
		word_t  data;
	} mem_wr_t;

	typedef struct packed {
		logic    valid;
		opcode_e opcode;
		logic    first;
		logic    last;
		maddr_t  out_addr;
	} alu_step_t;

	typedef struct packed {
		mem_wr_t wr;
		logic    last; // final write of a run
	} res_wr_t;

endpackage
